// File: test/aud_cases.txt
# A line is a command name followed by a decimal count and hex sample words.
# FULL gives a count and a base word. PLAY gives the expected length.
PLAY 0
REC 4 1234 abcd 8001 7ffe
STOP
PLAY 4
REC 3 0f0f f0f0 5a5a
PAUSE
REC 2 dead beef
PAUSE
REC 2 c3c3 0001
STOP
PLAY 5
FULL 70 a55a
PLAY 64
REC 2 ffff 0000
STOP
PLAY 2

// File: tb.f
design/aud_pkg.sv
design/aud_sram.sv
design/aud_recorder.sv
design/aud_player.sv
design/aud_ctrl.sv
design/aud_core.sv
test/aud_core_props.sv
test/tb_aud_core.sv

// File: test/tb_aud_core.sv
`timescale 1ns/1ps

module tb_aud_core import aud_pkg::*;;

logic                   clk;
logic                   rst_n;
logic                   lrc;
logic                   adc_data;
logic                   rec;
logic                   play;
logic                   pause;
logic                   stop;
logic                   dac_data;
aud_status_t            status;

logic [31:0]            lfsr;
logic [SAMPLE_BITS-1:0] word_q [$];    // words of the current REC or FULL line.
logic [SAMPLE_BITS-1:0] rec_q [$];     // memory contents from address 0 as the core should hold them.
aud_mode_e              model_mode;
logic [LEN_BITS-1:0]    model_len;

aud_core aud_core_inst (
    .i_clk(clk), .i_rst_n(rst_n), .i_lrc(lrc), .i_adc_data(adc_data),
    .i_rec(rec), .i_play(play), .i_pause(pause), .i_stop(stop),
    .o_dac_data(dac_data), .o_status(status)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic report_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
endtask

always @(aud_core_inst.aud_core_props_inst.fail_cnt) begin
    if (aud_core_inst.aud_core_props_inst.fail_cnt != 0) begin
        report_error("a concurrent assertion on aud_core failed");
    end
end

// ************************************************************************
// serial frames and command pulses
// ************************************************************************
// 20 left bits then 20 right bits with the DAC bit checked on every cycle.
task automatic run_frame(input logic use_word, input logic [SAMPLE_BITS-1:0] adc_word,
                         input logic dac_on, input logic [SAMPLE_BITS-1:0] dac_word);
    logic in_bit;
    logic exp_bit;
    int   i;
    for (i = 0; i < 40; i++) begin
        @(posedge clk);
        if (use_word && i < SAMPLE_BITS) begin
            in_bit = adc_word[SAMPLE_BITS-1-i];
        end
        else begin
            lfsr   = galois_step(lfsr);
            in_bit = lfsr[0];
        end
        lrc      <= (i >= 20);
        adc_data <= in_bit;
        @(negedge clk);
        exp_bit = 1'b0;
        if (dac_on && i >= 1 && i <= SAMPLE_BITS) begin
            exp_bit = dac_word[SAMPLE_BITS-i];    // MSB follows the first left edge.
        end
        assert (dac_data === exp_bit) else
            report_error($sformatf("FAILED o_dac_data: expected 0x%h, got 0x%h",
                                   exp_bit, dac_data));
    end
endtask

task automatic pulse_cmd(input logic r, input logic p, input logic ps, input logic s);
    @(posedge clk);
    rec   <= r;
    play  <= p;
    pause <= ps;
    stop  <= s;
    @(posedge clk);
    rec   <= 1'b0;
    play  <= 1'b0;
    pause <= 1'b0;
    stop  <= 1'b0;
endtask

task automatic wait_status(input aud_mode_e mode, input logic [LEN_BITS-1:0] len);
    aud_status_t exp_st;
    int          n;
    exp_st.mode = mode;
    exp_st.len  = len;
    n = 0;
    @(negedge clk);
    while (status !== exp_st && n < 32) begin
        @(negedge clk);
        n++;
    end
    assert (status === exp_st) else
        report_error($sformatf("FAILED o_status: expected 0x%h, got 0x%h", exp_st, status));
endtask

// ************************************************************************
// sessions
// ************************************************************************
task automatic record_session();
    int k;
    if (model_mode == MODE_IDLE) begin
        model_mode = MODE_REC;
        rec_q.delete();
    end
    pulse_cmd(1'b1, 1'b0, 1'b0, 1'b0);
    wait_status(model_mode, model_len);
    for (k = 0; k < word_q.size(); k++) begin
        run_frame(1'b1, word_q[k], 1'b0, '0);
        if (model_mode == MODE_REC) begin
            rec_q.push_back(word_q[k]);
            if (rec_q.size() == MEM_WORDS) begin
                model_mode = MODE_IDLE;       // a full memory ends the session by itself.
                model_len  = LEN_BITS'(MEM_WORDS);
            end
        end
    end
    wait_status(model_mode, model_len);
endtask

task automatic play_session(input int n);
    int k;
    assert (status.len === LEN_BITS'(n)) else
        report_error($sformatf("FAILED o_status.len: expected 0x%h, got 0x%h",
                               LEN_BITS'(n), status.len));
    if (model_mode == MODE_IDLE && model_len != '0) begin
        model_mode = MODE_PLAY;
    end
    pulse_cmd(1'b0, 1'b1, 1'b0, 1'b0);
    wait_status(model_mode, model_len);
    if (model_mode == MODE_PLAY) begin
        pulse_cmd(1'b1, 1'b0, 1'b0, 1'b0);    // i_rec is not taken while playing.
        wait_status(MODE_PLAY, model_len);
        for (k = 0; k < model_len; k++) begin
            run_frame(1'b0, '0, 1'b1, rec_q[k]);
        end
        model_mode = MODE_IDLE;
    end
    else begin
        run_frame(1'b0, '0, 1'b0, '0);
    end
    wait_status(model_mode, model_len);
endtask

initial begin
    int                     fd;
    int                     code;
    int                     n;
    int                     k;
    logic [SAMPLE_BITS-1:0] w;
    logic [SAMPLE_BITS-1:0] base;
    string                  cmd;
    logic [8*160-1:0]       skip_buf;

    lrc        = 1'b1;
    adc_data   = 1'b0;
    rec        = 1'b0;
    play       = 1'b0;
    pause      = 1'b0;
    stop       = 1'b0;
    rst_n      = 1'b1;
    lfsr       = 32'h69ca_87e6;
    model_mode = MODE_IDLE;
    model_len  = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b0;
    wait_status(MODE_IDLE, '0);
    assert (dac_data === 1'b0) else
        report_error($sformatf("FAILED o_dac_data: expected 0x0, got 0x%h", dac_data));

    fd = $fopen("test/aud_cases.txt", "r");
    if (fd == 0) begin
        report_error("could not open the cases file test/aud_cases.txt");
    end
    code = $fscanf(fd, "%s", cmd);
    while (code == 1) begin
        if (cmd[0] == "#") begin
            code = $fgets(skip_buf, fd);
        end
        else if (cmd == "REC" || cmd == "FULL") begin
            code = $fscanf(fd, "%d", n);
            word_q.delete();
            if (cmd == "REC") begin
                for (k = 0; k < n; k++) begin
                    code = $fscanf(fd, "%h", w);
                    word_q.push_back(w);
                end
            end
            else begin
                code = $fscanf(fd, "%h", base);
                for (k = 0; k < n; k++) begin
                    word_q.push_back(base ^ SAMPLE_BITS'(k * 16'h0351));
                end
            end
            record_session();
        end
        else if (cmd == "PAUSE") begin
            if (model_mode == MODE_REC) begin
                model_mode = MODE_PAUSE;
            end
            else if (model_mode == MODE_PAUSE) begin
                model_mode = MODE_REC;
            end
            pulse_cmd(1'b0, 1'b0, 1'b1, 1'b0);
            wait_status(model_mode, model_len);
        end
        else if (cmd == "STOP") begin
            if (model_mode == MODE_REC || model_mode == MODE_PAUSE) begin
                model_len = LEN_BITS'(rec_q.size());
            end
            model_mode = MODE_IDLE;
            pulse_cmd(1'b0, 1'b0, 1'b0, 1'b1);
            wait_status(model_mode, model_len);
        end
        else if (cmd == "PLAY") begin
            code = $fscanf(fd, "%d", n);
            play_session(n);
        end
        else begin
            report_error($sformatf("unknown command %s in the cases file", cmd));
        end
        code = $fscanf(fd, "%s", cmd);
    end
    $fclose(fd);

    if (aud_core_inst.aud_core_props_inst.fail_cnt == 0) begin
        $display("sim passed");
        $finish;
    end
    else begin
        $display("sim failed");
        $fatal(1);
    end
end

endmodule

// File: test/aud_core_props.sv
`timescale 1ns/1ps

module aud_core_props import aud_pkg::*; (
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_lrc,
    input aud_wr_t   i_wr,
    input aud_mode_e i_mode,
    input logic      i_dac_data
);

int fail_cnt = 0;

// a written word was captured while recording.
wr_in_rec_a: assert property (@(posedge i_clk) disable iff (i_rst_n)
    i_wr.we |-> $past(i_mode) == MODE_REC)
    else begin
        $error("memory write of a word not captured in record mode");
        fail_cnt++;
    end

// the write to the last address ends the session through the full pulse.
full_end_a: assert property (@(posedge i_clk) disable iff (i_rst_n)
    (i_wr.we && i_wr.addr == ADDR_BITS'(MEM_WORDS - 1)) |-> ##2 i_mode == MODE_IDLE)
    else begin
        $error("recording went on after the last memory address was written");
        fail_cnt++;
    end

dac_right_a: assert property (@(posedge i_clk) disable iff (i_rst_n)
    i_lrc |-> !i_dac_data)    // the right half-frame carries no DAC data.
    else begin
        $error("DAC bit high during the right half-frame");
        fail_cnt++;
    end

endmodule

bind aud_core aud_core_props aud_core_props_inst (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_lrc(i_lrc), .i_wr(wr),
    .i_mode(mode), .i_dac_data(o_dac_data)
);

// File: design/aud_core.sv
`timescale 1ns/1ps

module aud_core import aud_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_lrc,
    input  logic        i_adc_data,
    input  logic        i_rec,
    input  logic        i_play,
    input  logic        i_pause,
    input  logic        i_stop,
    output logic        o_dac_data,
    output aud_status_t o_status
);

aud_mode_e              mode;
aud_wr_t                wr;
logic                   rec_en;
logic                   play_en;
logic                   rec_start;
logic                   full;
logic                   play_done;
logic [ADDR_BITS-1:0]   wr_addr;
logic [ADDR_BITS-1:0]   rd_addr;
logic [SAMPLE_BITS-1:0] rd_data;
logic [LEN_BITS-1:0]    rec_len;

assign o_status = '{mode: mode, len: rec_len};

aud_ctrl aud_ctrl_inst (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_rec(i_rec), .i_play(i_play), .i_pause(i_pause), .i_stop(i_stop),
    .i_full(full), .i_play_done(play_done), .i_wr_addr(wr_addr),
    .o_rec_en(rec_en), .o_play_en(play_en), .o_rec_start(rec_start),
    .o_rec_len(rec_len), .o_mode(mode)
);

aud_recorder aud_recorder_inst (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_lrc(i_lrc), .i_adc_data(i_adc_data),
    .i_rec_en(rec_en), .i_rec_start(rec_start),
    .o_wr(wr), .o_full(full), .o_addr(wr_addr)
);

aud_player aud_player_inst (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_lrc(i_lrc), .i_play_en(play_en),
    .i_rec_len(rec_len), .i_rd_data(rd_data),
    .o_rd_addr(rd_addr), .o_dac_data(o_dac_data), .o_done(play_done)
);

aud_sram aud_sram_inst (
    .i_clk(i_clk), .i_wr(wr), .i_rd_addr(rd_addr), .o_rd_data(rd_data)
);

endmodule

// File: design/aud_ctrl.sv
`timescale 1ns/1ps

module aud_ctrl import aud_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_rec,
    input  logic                 i_play,
    input  logic                 i_pause,
    input  logic                 i_stop,
    input  logic                 i_full,
    input  logic                 i_play_done,
    input  logic [ADDR_BITS-1:0] i_wr_addr,
    output logic                 o_rec_en,
    output logic                 o_play_en,
    output logic                 o_rec_start,
    output logic [LEN_BITS-1:0]  o_rec_len,
    output aud_mode_e            o_mode
);

aud_mode_e           mode_r, mode_w;
logic [LEN_BITS-1:0] len_r, len_w;
logic                latch_r, latch_w;

assign o_rec_en    = (mode_r == MODE_REC);
assign o_play_en   = (mode_r == MODE_PLAY);
assign o_rec_start = (mode_r == MODE_IDLE) && i_rec;   // restarts the recorder address.
assign o_rec_len   = len_r;
assign o_mode      = mode_r;

always_comb begin
    mode_w  = mode_r;
    len_w   = len_r;
    latch_w = 1'b0;
    // the address is taken one cycle after stop so a write on the stop edge counts.
    if (latch_r) len_w = {1'b0, i_wr_addr};

    case (mode_r)
        MODE_IDLE: begin
            if (i_rec) mode_w = MODE_REC;
            else if (i_play && len_r != '0) mode_w = MODE_PLAY;
        end
        MODE_REC: begin
            if (i_full) begin
                mode_w = MODE_IDLE;
                len_w  = LEN_BITS'(MEM_WORDS);
            end
            else if (i_stop) begin
                mode_w  = MODE_IDLE;
                latch_w = 1'b1;
            end
            else if (i_pause) mode_w = MODE_PAUSE;
        end
        MODE_PAUSE: begin
            if (i_stop) begin
                mode_w  = MODE_IDLE;
                latch_w = 1'b1;
            end
            else if (i_pause) mode_w = MODE_REC;
        end
        default: begin
            if (i_play_done || i_stop) mode_w = MODE_IDLE;
        end
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        mode_r  <= MODE_IDLE;
        len_r   <= '0;
        latch_r <= 1'b0;
    end
    else begin
        mode_r  <= mode_w;
        len_r   <= len_w;
        latch_r <= latch_w;
    end
end

endmodule

// File: design/aud_player.sv
`timescale 1ns/1ps

module aud_player import aud_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_lrc,
    input  logic                   i_play_en,
    input  logic [LEN_BITS-1:0]    i_rec_len,
    input  logic [SAMPLE_BITS-1:0] i_rd_data,
    output logic [ADDR_BITS-1:0]   o_rd_addr,
    output logic                   o_dac_data,
    output logic                   o_done
);

logic                   lrc_d_r;
logic                   active_r, active_w;
logic [CNT_BITS-1:0]    cnt_r, cnt_w;
logic [LEN_BITS-1:0]    word_r, word_w;
logic [SAMPLE_BITS-1:0] shift_r, shift_w;
logic                   done_r, done_w;
logic                   lrc_fall;

assign lrc_fall   = lrc_d_r & ~i_lrc;
assign o_rd_addr  = word_r[ADDR_BITS-1:0];   // held through the high half-frame.
assign o_dac_data = active_r & shift_r[SAMPLE_BITS-1];
assign o_done     = done_r;

// ************************************************************************
// word and bit sequencing
// ************************************************************************
always_comb begin
    active_w = active_r;
    cnt_w    = cnt_r;
    word_w   = word_r;
    shift_w  = shift_r;
    done_w   = 1'b0;

    if (!i_play_en) begin
        active_w = 1'b0;
        word_w   = '0;
    end
    else if (lrc_fall && word_r < i_rec_len) begin
        active_w = 1'b1;
        cnt_w    = '0;
        shift_w  = i_rd_data;            // read data has been valid since the high half.
        word_w   = word_r + 1'b1;
    end
    else if (active_r) begin
        shift_w = {shift_r[SAMPLE_BITS-2:0], 1'b0};
        cnt_w   = cnt_r + 1'b1;
        if (cnt_r == LAST_BIT) begin
            active_w = 1'b0;
            done_w   = (word_r == i_rec_len);
        end
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        lrc_d_r  <= 1'b0;
        active_r <= 1'b0;
        cnt_r    <= '0;
        word_r   <= '0;
        done_r   <= 1'b0;
    end
    else begin
        lrc_d_r  <= i_lrc;
        active_r <= active_w;
        cnt_r    <= cnt_w;
        word_r   <= word_w;
        done_r   <= done_w;
    end
end

always_ff @(posedge i_clk) begin
    shift_r <= shift_w;
end

endmodule

// File: design/aud_recorder.sv
`timescale 1ns/1ps

module aud_recorder import aud_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_lrc,
    input  logic                 i_adc_data,
    input  logic                 i_rec_en,
    input  logic                 i_rec_start,
    output aud_wr_t              o_wr,
    output logic                 o_full,
    output logic [ADDR_BITS-1:0] o_addr
);

logic                   lrc_d_r;
logic                   active_r, active_w;
logic [CNT_BITS-1:0]    cnt_r, cnt_w;
logic [SAMPLE_BITS-1:0] shift_r, shift_w;
logic [ADDR_BITS-1:0]   addr_r, addr_w;
logic                   we_r, we_w;
logic                   full_r, full_w;
logic                   lrc_fall;
logic                   wr_fire;

assign lrc_fall = lrc_d_r & ~i_lrc;    // first clock of a left half-frame.
assign wr_fire  = we_r & i_rec_en;     // a word finished on a stop or pause edge is dropped.

always_comb begin
    o_wr.we   = wr_fire;
    o_wr.addr = addr_r;
    o_wr.data = shift_r;
end

assign o_full = full_r;
assign o_addr = addr_r;

always_comb begin
    active_w = active_r;
    cnt_w    = cnt_r;
    shift_w  = shift_r;
    addr_w   = addr_r;
    we_w     = 1'b0;
    full_w   = 1'b0;

    if (wr_fire) begin
        addr_w = addr_r + 1'b1;
        full_w = (addr_r == ADDR_BITS'(MEM_WORDS - 1));   // the address wraps to zero here.
    end
    if (i_rec_start) begin
        addr_w = '0;
    end

    if (!i_rec_en) begin
        active_w = 1'b0;                 // any partial word is thrown away.
    end
    else if (lrc_fall) begin
        active_w = 1'b1;
        cnt_w    = CNT_BITS'(1);
        shift_w  = {shift_r[SAMPLE_BITS-2:0], i_adc_data};
    end
    else if (active_r && !i_lrc) begin
        shift_w = {shift_r[SAMPLE_BITS-2:0], i_adc_data};
        cnt_w   = cnt_r + 1'b1;
        if (cnt_r == LAST_BIT) begin
            active_w = 1'b0;             // later bits of this half-frame are ignored.
            we_w     = 1'b1;
        end
    end
    else begin
        active_w = 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        lrc_d_r  <= 1'b0;
        active_r <= 1'b0;
        cnt_r    <= '0;
        addr_r   <= '0;
        we_r     <= 1'b0;
        full_r   <= 1'b0;
    end
    else begin
        lrc_d_r  <= i_lrc;
        active_r <= active_w;
        cnt_r    <= cnt_w;
        addr_r   <= addr_w;
        we_r     <= we_w;
        full_r   <= full_w;
    end
end

// capture shift register.
always_ff @(posedge i_clk) begin
    shift_r <= shift_w;
end

endmodule

// File: design/aud_sram.sv
`timescale 1ns/1ps

module aud_sram import aud_pkg::*; (
    input  logic                   i_clk,
    input  aud_wr_t                i_wr,
    input  logic [ADDR_BITS-1:0]   i_rd_addr,
    output logic [SAMPLE_BITS-1:0] o_rd_data
);

logic [SAMPLE_BITS-1:0] mem_r [MEM_WORDS];

// ************************************************************************
// one write port and one registered read port
// ************************************************************************
always_ff @(posedge i_clk) begin
    if (i_wr.we) begin
        mem_r[i_wr.addr] <= i_wr.data;
    end
end

// data follows the address by one cycle.
always_ff @(posedge i_clk) begin
    o_rd_data <= mem_r[i_rd_addr];
end

endmodule

// File: design/aud_pkg.sv
package aud_pkg;

    // ************************************************************************
    // sizes
    // ************************************************************************
    localparam int SAMPLE_BITS = 16;
    localparam int MEM_WORDS   = 64;       // small so a full memory is quick to reach.
    localparam int ADDR_BITS   = 6;
    localparam int LEN_BITS    = 7;        // one bit wider than an address to hold 64.
    localparam int CNT_BITS    = 4;        // bit slot counter inside one word.

    // the bit counter value of the 16th bit of a word.
    localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(SAMPLE_BITS - 1);

    // ************************************************************************
    // types
    // ************************************************************************
    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_REC   = 2'd1,
        MODE_PAUSE = 2'd2,
        MODE_PLAY  = 2'd3
    } aud_mode_e;

    // one write into the sample memory.
    typedef struct packed {
        logic                   we;
        logic [ADDR_BITS-1:0]   addr;
        logic [SAMPLE_BITS-1:0] data;
    } aud_wr_t;

    // status seen outside the core.
    typedef struct packed {
        aud_mode_e              mode;
        logic [LEN_BITS-1:0]    len;
    } aud_status_t;

endpackage
